//--- sources.f
+incdir+include
source/ld_pkg.sv
source/ld_if.sv
source/op_fetch.sv
source/ld_decoder.sv
source/mem_load.sv
source/cpu_regs.sv
source/ld_core.sv
test/ld_core_sva.sv
test/ld_core_tb.sv

//--- Bender.yml
package:
  name: ld_core

export_include_dirs:
  - include

sources:
  - files:
      - source/ld_pkg.sv
      - source/ld_if.sv
      - source/op_fetch.sv
      - source/ld_decoder.sv
      - source/mem_load.sv
      - source/cpu_regs.sv
      - source/ld_core.sv
  - target: test
    files:
      - test/ld_core_sva.sv
      - test/ld_core_tb.sv

//--- test/ld_core_tb.sv
// testbench for ld_core; programs never use a freshly loaded register as base, run limit from length
`timescale 1ns/100ps
`include "ld_settings.svh"

module ld_core_tb;
    import ld_pkg::*;

    logic        clk = 1'b0;
    logic        rst;
    logic        run;
    logic        load_we;
    load_sel_e   load_sel;
    logic [15:0] load_addr;
    logic [31:0] load_data;
    logic        wb_valid;
    reg_idx_t    wb_reg;
    logic [31:0] wb_data;
    logic        illegal;
    logic        halted;

    logic [31:0] seed = 32'd65;
    logic [7:0]  prog [$];
    logic [34:0] exp_q [$];            // {reg, merged value}
    logic [34:0] head;
    logic [7:0]  dmem_m [`DATA_DEPTH]; // mirror of data memory
    logic [31:0] regs_m [8];
    int          exp_ill = 0;
    int          ill_seen = 0;
    int          val_err = 0;
    int          other_err = 0;
    int          cyc = 0;
    int          limit = 100;

    ld_core i_dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    task automatic port_write(input load_sel_e sel, input int a, input logic [31:0] d);
        @(posedge clk);
        #1;
        load_we   = 1'b1;
        load_sel  = sel;
        load_addr = a[15:0];
        load_data = d;
    endtask

    task automatic port_idle();
        @(posedge clk);
        #1 load_we = 1'b0;
    endtask

    task automatic fill_data_and_regs();
        logic [31:0] r;
        for (int a = 0; a < `DATA_DEPTH; a++) begin
            r = lcg_next();
            dmem_m[a] = r[23:16];
            port_write(LOAD_DATA, a, {24'd0, r[23:16]});
        end
        for (int i = 0; i < 8; i++) begin
            regs_m[i] = lcg_next();
        end
        regs_m[6] = 32'h0000_0100;  // base for offset loads
        regs_m[7] = 32'h0000_03fe;  // base near the top, long read wraps
        for (int i = 0; i < 8; i++) begin
            port_write(LOAD_REG, i, regs_m[i]);
        end
        port_idle();
    endtask

    task automatic write_program();
        for (int i = 0; i < prog.size(); i++) begin
            port_write(LOAD_PROG, i, {24'd0, prog[i]});
        end
        port_idle();
    endtask

    // walks the bytes by the encoding rules, queues write-backs
    task automatic predict();
        int          p;
        int          k;
        int          n;
        logic [7:0]  b0;
        logic [7:0]  d;
        logic [1:0]  sz;
        logic [23:0] addr;
        logic [31:0] raw;
        logic [31:0] nv;
        p = 0;
        while (p < prog.size() && prog[p] != 8'h00) begin
            b0 = prog[p];
            if (!(b0[7:6] == 2'b10 || (b0[7:6] == 2'b11 && !b0[3])) ||
                (b0[6] && b0[1:0] == 2'b11)) begin
                exp_ill++;  // skipped opcode
                p++;
            end else begin
                sz = b0[5:4];
                if (!b0[6]) begin
                    addr = regs_m[b0[2:0]][23:0];
                    if (b0[3]) begin
                        addr = addr + {{16{prog[p+1][7]}}, prog[p+1]};
                        p += 2;
                    end else begin
                        p += 1;
                    end
                end else begin
                    n    = b0[1:0] + 1;  // address bytes, lsb first
                    addr = '0;
                    for (k = 0; k < n; k++) addr[8*k +: 8] = prog[p+1+k];
                    p += 1 + n;
                end
                d = prog[p];
                p++;
                if (d[7:3] != 5'b00100 || sz == 2'b11) begin
                    exp_ill++;
                end else begin
                    n   = (sz == 2'b00) ? 1 : (sz == 2'b01) ? 2 : 4;
                    raw = '0;
                    for (k = 0; k < n; k++) raw[8*k +: 8] = dmem_m[(addr + k) % `DATA_DEPTH];
                    nv = regs_m[d[2:0]];
                    if (n == 1)      nv[7:0]  = raw[7:0];
                    else if (n == 2) nv[15:0] = raw[15:0];
                    else             nv       = raw;
                    regs_m[d[2:0]] = nv;
                    exp_q.push_back({d[2:0], nv});
                end
            end
        end
    endtask

    task automatic run_until_halt();
        limit = 20 * prog.size() + 100;
        @(posedge clk);
        #1 run = 1'b1;
        @(negedge clk);
        while (!halted) @(negedge clk);
        repeat (5) @(negedge clk);  // late write-backs come within 3 cycles
        @(posedge clk);
        #1 run = 1'b0;
    endtask

    task automatic check_counts();
        assert (exp_q.size() == 0) else begin
            other_err++;
            $display("%0d expected write-backs never arrived", exp_q.size());
        end
        assert (ill_seen == exp_ill) else begin
            val_err++;
            $display("error at %0t: %0d illegal pulses, expected %0d", $time, ill_seen, exp_ill);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1 rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    endtask

    // compare each write-back with the queue head
    always @(negedge clk) begin
        if (!rst && illegal) ill_seen++;
        if (!rst && wb_valid) begin
            assert (exp_q.size() > 0) else begin
                other_err++;
                $display("write-back to r%0d at %0t was not expected", wb_reg, $time);
            end
            if (exp_q.size() > 0) begin
                head = exp_q.pop_front();
                assert (wb_reg == head[34:32] && wb_data == head[31:0]) else begin
                    val_err++;
                    $display("error at %0t: r%0d = %h, expected r%0d = %h",
                             $time, wb_reg, wb_data, head[34:32], head[31:0]);
                end
            end
        end
    end

    // watchdog while running
    always @(posedge clk) begin
        if (run) begin
            cyc++;
            if (cyc > limit) begin
                $display("timeout: the core never halted within %0d cycles", limit);
                $display("Test failed");
                $finish;
            end
        end else begin
            cyc = 0;
        end
    end

    initial begin
        rst       = 1'b1;
        run       = 1'b0;
        load_we   = 1'b0;
        load_sel  = LOAD_PROG;
        load_addr = '0;
        load_data = '0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        fill_data_and_regs();
        // (r) each size, offsets, absolute 8/16/24, illegal forms, halt, dead code
        prog = {8'h86, 8'h20, 8'h97, 8'h21, 8'ha7, 8'h22,
                8'h8e, 8'h05, 8'h23, 8'hae, 8'hf0, 8'h24, 8'h9f, 8'h7f, 8'h25,
                8'hc0, 8'h33, 8'h20, 8'hd1, 8'h34, 8'h12, 8'h21,
                8'he2, 8'hff, 8'h03, 8'h80, 8'h22,
                8'h48, 8'h86, 8'h37, 8'hb6, 8'h23, 8'hf0, 8'h10, 8'h23,
                8'h86, 8'h23, 8'h00, 8'h86, 8'h24};
        write_program();
        predict();
        run_until_halt();
        check_counts();
        apply_reset();
        assert (!halted) else begin
            other_err++;
            $display("halted stayed high after the second reset");
        end
        prog = {8'hc1, 8'h00, 8'h01, 8'h25, 8'h8e, 8'h01, 8'h21, 8'h00};
        write_program();
        predict();
        run_until_halt();
        check_counts();
        $display("value errors %0d, other errors %0d, assertion failures %0d",
                 val_err, other_err, i_dut.i_sva.fail_cnt);
        if (val_err == 0 && other_err == 0 && i_dut.i_sva.fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- test/ld_core_sva.sv
// output checks bound into ld_core; fail_cnt is read back hierarchically by the testbench
`timescale 1ns/100ps

module ld_core_sva (
    input logic clk,
    input logic rst,
    input logic wb_valid,
    input logic illegal,
    input logic halted
);
    int fail_cnt = 0;

    // each decoded instruction owns one slot
    a_wb_ill_excl: assert property (@(posedge clk) disable iff (rst) !(wb_valid && illegal))
        else begin
            fail_cnt++;
            $error("wb_valid and illegal high in the same cycle");
        end

    a_halt_sticky: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
        else begin
            fail_cnt++;
            $error("halted dropped without reset");
        end

    // pipeline drains within 3 cycles of the halt
    a_no_wb_after_halt: assert property (@(posedge clk) disable iff (rst)
                                         halted && $past(halted, 3) |-> !wb_valid)
        else begin
            fail_cnt++;
            $error("write-back more than 3 cycles after halt");
        end

    a_reset_quiet: assert property (@(posedge clk) $fell(rst) |-> !wb_valid && !illegal && !halted)
        else begin
            fail_cnt++;
            $error("outputs not low after reset");
        end

endmodule

bind ld_core ld_core_sva i_sva (.clk, .rst, .wb_valid, .illegal, .halted);

//--- source/ld_core.sv
// load slice top; load port only acts while run is low, no interlock on a freshly loaded base
`timescale 1ns/100ps
`include "ld_settings.svh"

module ld_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              run,
    input  logic              load_we,
    input  ld_pkg::load_sel_e load_sel,
    input  logic [15:0]       load_addr,
    input  logic [31:0]       load_data,
    output logic              wb_valid,
    output ld_pkg::reg_idx_t  wb_reg,
    output logic [31:0]       wb_data,
    output logic              illegal,
    output logic              halted
);
    import ld_pkg::*;

    wire               load_en = load_we && !run;  // writes ignored while running
    logic [15:0]       op;
    logic [1:0]        adv;
    reg_idx_t          base_sel;
    logic [`REG_W-1:0] base_data;

    ld_req_if i_req ();
    ld_wb_if  i_wb ();

    op_fetch i_fetch (
        .clk, .rst, .load_we(load_en), .load_sel, .load_addr, .load_data,
        .adv, .op
    );

    ld_decoder i_dec (
        .clk, .rst, .run, .op, .adv, .req(i_req.dec), .illegal, .halted
    );

    mem_load i_mem (
        .clk, .rst, .load_we(load_en), .load_sel, .load_addr, .load_data,
        .req(i_req.agu), .base_sel, .base_data, .wb(i_wb.src)
    );

    cpu_regs i_regs (
        .clk, .rst, .load_we(load_en), .load_sel, .load_addr, .load_data,
        .base_sel, .base_data, .wb(i_wb.dst),
        .wb_valid, .wb_reg, .wb_data
    );

endmodule

//--- source/cpu_regs.sv
// eight 32-bit registers; load port and write-back never overlap, write-back takes priority anyway
`timescale 1ns/100ps
`include "ld_settings.svh"

module cpu_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               load_we,
    input  ld_pkg::load_sel_e  load_sel,
    input  logic [15:0]        load_addr,
    input  logic [31:0]        load_data,
    input  ld_pkg::reg_idx_t   base_sel,
    output logic [`REG_W-1:0]  base_data,
    ld_wb_if.dst               wb,
    output logic               wb_valid,
    output ld_pkg::reg_idx_t   wb_reg,
    output logic [`REG_W-1:0]  wb_data   // full new value
);
    import ld_pkg::*;

    logic [`REG_W-1:0] regs [8];
    logic [`REG_W-1:0] cur, merged;

    assign base_data = regs[base_sel];  // combinational base port
    assign cur       = regs[wb.dst_sel];

    // keep the bits above the operand size
    always_comb begin
        case (wb.size)
            SZ_BYTE: merged = {cur[`REG_W-1:8],  wb.data[7:0]};
            SZ_WORD: merged = {cur[`REG_W-1:16], wb.data[15:0]};
            default: merged = wb.data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wb.valid) begin
            regs[wb.dst_sel] <= merged;
            wb_reg           <= wb.dst_sel;
            wb_data          <= merged;
        end else if (load_we && load_sel == LOAD_REG) begin
            regs[load_addr[2:0]] <= load_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) wb_valid <= 1'b0;
        else     wb_valid <= wb.valid;
    end

endmodule

//--- source/mem_load.sv
// address adder and data memory read; 2 cycles from request to write-back, DATA_DEPTH a power of two
`timescale 1ns/100ps
`include "ld_settings.svh"

module mem_load (
    input  logic              clk,
    input  logic              rst,
    input  logic              load_we,
    input  ld_pkg::load_sel_e load_sel,
    input  logic [15:0]       load_addr,
    input  logic [31:0]       load_data,
    ld_req_if.agu             req,
    output ld_pkg::reg_idx_t  base_sel,
    input  logic [31:0]       base_data,
    ld_wb_if.src              wb
);
    import ld_pkg::*;

    localparam int DA_W = $clog2(`DATA_DEPTH);

    logic [7:0]      dmem [`DATA_DEPTH];
    addr_t           ea, ea_q;
    logic            v_q;
    size_e           sz_q;
    reg_idx_t        dst_q;
    logic [DA_W-1:0] a0, a1, a2, a3;
    logic [`REG_W-1:0] raw;

    assign base_sel = req.base_sel;
    assign ea = req.use_base ? addr_t'(base_data) + req.offset : req.offset;  // mod 2^24

    always_ff @(posedge clk) begin
        if (load_we && load_sel == LOAD_DATA) dmem[load_addr[DA_W-1:0]] <= load_data[7:0];
    end

    // little-endian byte lanes, wrap at DATA_DEPTH
    assign a0 = ea_q[DA_W-1:0];
    assign a1 = a0 + DA_W'(1);
    assign a2 = a0 + DA_W'(2);
    assign a3 = a0 + DA_W'(3);

    always_comb begin
        case (sz_q)
            SZ_BYTE: raw = {24'd0, dmem[a0]};
            SZ_WORD: raw = {16'd0, dmem[a1], dmem[a0]};
            SZ_LONG: raw = {dmem[a3], dmem[a2], dmem[a1], dmem[a0]};
            default: raw = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            v_q      <= 1'b0;
            wb.valid <= 1'b0;
        end else begin
            v_q      <= req.valid;  // stage 1 address
            wb.valid <= v_q;        // stage 2 data
        end
    end

    always_ff @(posedge clk) begin
        ea_q       <= ea;
        sz_q       <= req.size;
        dst_q      <= req.dst;
        wb.data    <= raw;
        wb.size    <= sz_q;
        wb.dst_sel <= dst_q;
    end

endmodule

//--- source/ld_decoder.sv
// LD R,(mem) decoder; illegal is delayed 3 cycles to sit in the write-back slot, halt lasts until rst
`timescale 1ns/100ps
`include "ld_settings.svh"

module ld_decoder (
    input  logic        clk,
    input  logic        rst,
    input  logic        run,
    input  logic [15:0] op,
    output logic [1:0]  adv,
    ld_req_if.dec       req,
    output logic        illegal,
    output logic        halted
);
    import ld_pkg::*;

    localparam logic [4:0] DST_TAG = 5'b00100;  // dest byte bits 7:3

    dec_state_e state, state_nx;
    logic [7:0] b0, b1;
    logic       is_load;
    logic       ill_now;
    logic [2:0] ill_dly;     // aligns illegal with the wb slot

    // gathered across cycles
    size_e      size_q;
    logic       sz_bad_q;    // size code 3 seen
    logic       use_base_q;
    reg_idx_t   base_q;
    addr_t      off_q;
    logic       two_left_q;  // 24-bit address, two bytes still to come

    function automatic logic dest_ok(input logic [7:0] b);
        return b[7:3] == DST_TAG;
    endfunction

    assign b0      = op[7:0];
    assign b1      = op[15:8];
    assign is_load = (b0[7:6] == 2'b10) || (b0[7:6] == 2'b11 && !b0[3]);

    always_comb begin
        state_nx     = state;
        adv          = 2'd0;
        ill_now      = 1'b0;
        req.valid    = 1'b0;
        req.use_base = use_base_q;
        req.base_sel = base_q;
        req.offset   = off_q;
        req.size     = size_q;
        req.dst      = b0[2:0];
        case (state)
            IDLE: if (run) state_nx = OPC;
            OPC: begin
                if (b0 == 8'h00) begin
                    state_nx = HALT;                       // nothing consumed
                end else if (!is_load || (b0[6] && b0[1:0] == 2'b11)) begin
                    ill_now = 1'b1;                        // skip the byte
                    adv     = 2'd1;
                end else if (!b0[6] && !b0[3]) begin
                    // (R) with no offset, dest byte already in window
                    adv          = 2'd2;
                    req.use_base = 1'b1;
                    req.base_sel = b0[2:0];
                    req.offset   = '0;
                    req.size     = size_e'(b0[5:4]);
                    req.dst      = b1[2:0];
                    if (dest_ok(b1) && b0[5:4] != 2'b11) req.valid = 1'b1;
                    else                                 ill_now   = 1'b1;
                end else if (!b0[6]) begin
                    adv      = 2'd1;                       // offset follows
                    state_nx = OFF8;
                end else begin
                    adv      = 2'd2;                       // opcode + low address byte
                    state_nx = (b0[1:0] == 2'b00) ? DEST : ADDR;
                end
            end
            OFF8: begin
                adv        = 2'd2;                         // offset + dest
                state_nx   = OPC;
                req.offset = {{(`ADDR_W-8){b0[7]}}, b0};
                req.dst    = b1[2:0];
                if (dest_ok(b1) && !sz_bad_q) req.valid = 1'b1;
                else                          ill_now   = 1'b1;
            end
            ADDR: begin
                adv      = two_left_q ? 2'd2 : 2'd1;
                state_nx = DEST;
            end
            DEST: begin
                adv      = 2'd1;
                state_nx = OPC;
                if (dest_ok(b0) && !sz_bad_q) req.valid = 1'b1;
                else                          ill_now   = 1'b1;
            end
            HALT: ;                                        // wait for rst
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            ill_dly <= '0;
        end else begin
            state   <= state_nx;
            ill_dly <= {ill_dly[1:0], ill_now};
        end
    end

    // operand capture
    always_ff @(posedge clk) begin
        case (state)
            OPC: begin
                size_q     <= size_e'(b0[5:4]);
                sz_bad_q   <= b0[5:4] == 2'b11;
                use_base_q <= !b0[6];
                base_q     <= b0[2:0];
                off_q      <= addr_t'(b1);                 // low address byte
                two_left_q <= b0[1:0] == 2'b10;
            end
            ADDR: begin
                if (two_left_q) off_q[`ADDR_W-1:8] <= {b1, b0};
                else            off_q[15:8]        <= b0;
            end
            default: ;
        endcase
    end

    assign illegal = ill_dly[2];
    assign halted  = state == HALT;

endmodule

//--- source/op_fetch.sv
// program memory and pc; load port writes must be gated off while running, pc wraps at PROG_DEPTH
`timescale 1ns/100ps
`include "ld_settings.svh"

module op_fetch (
    input  logic               clk,
    input  logic               rst,
    input  logic               load_we,
    input  ld_pkg::load_sel_e  load_sel,
    input  logic [15:0]        load_addr,
    input  logic [31:0]        load_data,
    input  logic [1:0]         adv,       // bytes consumed by decoder
    output logic [15:0]        op         // {byte at pc+1, byte at pc}
);
    import ld_pkg::*;

    localparam int PA_W = $clog2(`PROG_DEPTH);

    logic [7:0]      pmem [`PROG_DEPTH];
    logic [PA_W-1:0] pc;
    logic [PA_W-1:0] pc_nx1;

    // byte writes from the load port
    always_ff @(posedge clk) begin
        if (load_we && load_sel == LOAD_PROG) begin
            pmem[load_addr[PA_W-1:0]] <= load_data[7:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc + PA_W'(adv);  // 0..2 per cycle
        end
    end

    assign pc_nx1 = pc + 1'b1;  // wraps with pc
    assign op     = {pmem[pc_nx1], pmem[pc]};

endmodule

//--- source/ld_if.sv
// decoder to load unit and load unit to register file links; plain strobes, no back-pressure
`timescale 1ns/100ps
`include "ld_settings.svh"

interface ld_req_if;
    import ld_pkg::*;

    logic     valid;     // one cycle per load
    logic     use_base;  // add base register
    reg_idx_t base_sel;
    addr_t    offset;    // sign-extended off8 or absolute address
    size_e    size;
    reg_idx_t dst;

    modport dec (output valid, use_base, base_sel, offset, size, dst);
    modport agu (input  valid, use_base, base_sel, offset, size, dst);
endinterface

interface ld_wb_if;
    import ld_pkg::*;

    logic              valid;
    reg_idx_t          dst_sel;  // destination register
    size_e             size;
    logic [`REG_W-1:0] data;  // raw bytes, zero-extended

    modport src (output valid, dst_sel, size, data);
    modport dst (input  valid, dst_sel, size, data);
endinterface

//--- source/ld_pkg.sv
// shared types of the load slice; size code 3 has no enum member and is handled as illegal
`include "ld_settings.svh"

package ld_pkg;

    // control decoder states
    typedef enum logic [2:0] {
        IDLE,
        OPC,    // opcode byte in window
        OFF8,   // offset byte + destination byte
        ADDR,   // upper absolute address bytes
        DEST,   // destination byte alone
        HALT
    } dec_state_e;

    // operand size, opcode bits 5:4
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_WORD = 2'd1,
        SZ_LONG = 2'd2
    } size_e;

    typedef enum logic [1:0] {LOAD_PROG, LOAD_DATA, LOAD_REG} load_sel_e;

    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [2:0]         reg_idx_t;

endpackage

//--- include/ld_settings.svh
// sizes for the load slice; both memory depths must be powers of two, addresses wrap at them
`ifndef LD_SETTINGS_SVH
`define LD_SETTINGS_SVH

// program memory, bytes
`define PROG_DEPTH 256
// data memory, bytes
`define DATA_DEPTH 1024

`define REG_W  32   // register width
`define ADDR_W 24   // cpu address width

`endif
